/* design/serial_config.svh */
// timing and width constants for the serial port
// included by the package and by every RTL file that sizes a counter

`ifndef SERIAL_CONFIG_SVH
`define SERIAL_CONFIG_SVH

// data bits per frame
`define SERIAL_DATA_BITS 8

// transmit shift length: idle lead bit, start, data and stop
`define SERIAL_FRAME_BITS 11

// cycles the start bit must stay low before it is accepted
`define SERIAL_STABLE_COUNT 8

// largest baud period in clock cycles, sizes the phase counters
`define SERIAL_BAUD_PERIOD_MAX 64

// depth of the rxd synchronizer
`define SERIAL_SYNC_STAGES 3

`endif

/* design/serial_pkg.sv */
// shared types of the serial port
// the host command and status words, and the transmit frame layout

`include "serial_config.svh"

package serial_pkg;

    // ========================================================================
    // data
    // ========================================================================

    typedef logic [`SERIAL_DATA_BITS-1:0] serial_byte_t;

    // lead_bit sits in bit 0 and leaves the line first
    typedef struct packed {
        logic         stop_bit;
        serial_byte_t data;
        logic         start_bit;
        logic         lead_bit;
    } tx_frame_t;

    // ========================================================================
    // host side
    // ========================================================================

    typedef struct packed {
        logic         start_tx;
        logic         start_rx;
        logic         rx_enable;
        serial_byte_t tx_data;
    } host_cmd_t;

    typedef struct packed {
        logic         ti;
        logic         ri;
        serial_byte_t rx_data;
    } host_status_t;

endpackage

/* design/serial_ctrl.sv */
// port controller: decides whether the port sends or receives
// registers the baud tick and keeps the ti/ri flags for the host

module serial_ctrl (
    input  logic                  clk,
    input  logic                  reset_n,
    input  serial_pkg::host_cmd_t cmd,
    input  logic                  timer_trigger,
    input  logic                  tx_done,
    input  logic                  rx_done,
    output logic                  baud_tick,
    output logic                  tx_go,
    output logic                  rx_go,
    output logic                  ti,
    output logic                  ri
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_TX,
        ST_RX
    } port_state_t;

    port_state_t state;

    // one tick per bit time, one cycle behind the timer
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            baud_tick <= 1'b0;
        end else begin
            baud_tick <= timer_trigger;
        end
    end

    // ========================================================================
    // mode FSM
    // ========================================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= ST_IDLE;
            tx_go <= 1'b0;
            rx_go <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // receive wins while enabled, start_tx is ignored then
                    if (cmd.rx_enable) begin
                        if (cmd.start_rx) begin
                            state <= ST_RX;
                            rx_go <= 1'b1;
                        end
                    end else if (cmd.start_tx) begin
                        state <= ST_TX;
                        tx_go <= 1'b1;
                    end
                end
                ST_TX: begin
                    if (tx_done) begin
                        state <= ST_IDLE;
                        tx_go <= 1'b0;
                    end
                end
                ST_RX: begin
                    // dropping rx_enable abandons the armed receiver
                    if (rx_done || !cmd.rx_enable) begin
                        state <= ST_IDLE;
                        rx_go <= 1'b0;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                    tx_go <= 1'b0;
                    rx_go <= 1'b0;
                end
            endcase
        end
    end

    // host flags, a set beats a clear in the same cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ti <= 1'b0;
            ri <= 1'b0;
        end else begin
            if (tx_done) begin
                ti <= 1'b1;
            end else if (cmd.start_tx) begin
                ti <= 1'b0;
            end
            if (rx_done) begin
                ri <= 1'b1;
            end else if (cmd.start_rx) begin
                ri <= 1'b0;
            end
        end
    end

    // half duplex
    a_one_side: assert property (@(posedge clk) disable iff (!reset_n)
        !(tx_go && rx_go))
        else $error("tx_go and rx_go high together");

endmodule

/* design/serial_tx.sv */
// transmit side of the serial port
// shifts one frame out on txd, one bit per baud tick, while tx_go is held

`include "serial_config.svh"

module serial_tx (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     tx_go,
    input  logic                     baud_tick,
    input  serial_pkg::serial_byte_t tx_data,
    output logic                     tx_done,
    output logic                     txd
);

    import serial_pkg::*;

    localparam int CNT_W = $clog2(`SERIAL_FRAME_BITS + 1);

    tx_frame_t        load_frame;
    tx_frame_t        shifter;
    logic             armed;
    logic [CNT_W-1:0] shift_cnt;

    assign load_frame = '{stop_bit: 1'b1, data: tx_data, start_bit: 1'b0, lead_bit: 1'b1};

    // ========================================================================
    // frame shifter
    // ========================================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            shifter   <= '1;
            armed     <= 1'b0;
            shift_cnt <= '0;
        end else if (!tx_go) begin
            shifter   <= load_frame;
            armed     <= 1'b0;
            shift_cnt <= '0;
        end else if (!armed) begin
            // first tick only lines up with the bit grid
            shifter <= load_frame;
            if (baud_tick) begin
                armed <= 1'b1;
            end
        end else if (baud_tick && !tx_done) begin
            // ones fill in from the top, so the line idles high afterwards
            shifter   <= tx_frame_t'({1'b1, shifter[`SERIAL_FRAME_BITS-1:1]});
            shift_cnt <= shift_cnt + 1'b1;
        end
    end

    // high from the cycle the last shift shows until tx_go drops
    assign tx_done = tx_go && (shift_cnt == CNT_W'(`SERIAL_FRAME_BITS));

    assign txd = shifter.lead_bit;

    // line stays idle whenever no frame is running
    a_idle_line: assert property (@(posedge clk) disable iff (!reset_n)
        !tx_go |-> txd)
        else $error("txd low while tx_go is low");

endmodule

/* design/serial_rx.sv */
// receive side of the serial port
// filters the start bit, locks onto its phase against the baud tick and
// samples eight data bits plus the stop slot before raising rx_done

`include "serial_config.svh"

module serial_rx (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     rx_go,
    input  logic                     baud_tick,
    input  logic                     rxd,
    output logic                     rx_done,
    output serial_pkg::serial_byte_t rx_data
);

    localparam int SYNC_MSB = `SERIAL_SYNC_STAGES - 1;
    localparam int PHASE_W  = $clog2(`SERIAL_BAUD_PERIOD_MAX);
    localparam int STABLE_W = $clog2(`SERIAL_STABLE_COUNT + 1);
    localparam int BIT_W    = $clog2(`SERIAL_DATA_BITS + 1);

    typedef enum logic [2:0] {
        RX_WAIT_EDGE,
        RX_START_CHECK,
        RX_DATA,
        RX_STOP,
        RX_DONE
    } rx_state_t;

    rx_state_t           state;
    logic [SYNC_MSB:0]   rxd_sync;
    logic                rxd_s;
    logic                rxd_fall;
    logic [STABLE_W-1:0] stable_cnt;
    logic [PHASE_W-1:0]  phase_cnt;
    logic [PHASE_W-1:0]  phase_save;
    logic [BIT_W-1:0]    bit_cnt;
    logic                sample;

    // ========================================================================
    // line synchronizer and phase counter
    // ========================================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rxd_sync  <= '1;
            phase_cnt <= '0;
        end else begin
            rxd_sync <= {rxd_sync[SYNC_MSB-1:0], rxd};
            // position inside the current bit time
            if (baud_tick) begin
                phase_cnt <= '0;
            end else begin
                phase_cnt <= phase_cnt + 1'b1;
            end
        end
    end

    assign rxd_s    = rxd_sync[SYNC_MSB];
    assign rxd_fall = rxd_sync[SYNC_MSB] & ~rxd_sync[SYNC_MSB-1];
    assign sample   = (phase_cnt == phase_save);

    // ========================================================================
    // sequencer
    // ========================================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= RX_WAIT_EDGE;
            stable_cnt <= '0;
            phase_save <= '0;
            bit_cnt    <= '0;
        end else if (!rx_go) begin
            state      <= RX_WAIT_EDGE;
            stable_cnt <= '0;
            bit_cnt    <= '0;
        end else begin
            case (state)
                RX_WAIT_EDGE: begin
                    stable_cnt <= '0;
                    bit_cnt    <= '0;
                    if (rxd_fall) begin
                        state <= RX_START_CHECK;
                    end
                end
                RX_START_CHECK: begin
                    // short low pulse is a glitch, not a start bit
                    if (rxd_s) begin
                        state <= RX_WAIT_EDGE;
                    end else if (stable_cnt == STABLE_W'(`SERIAL_STABLE_COUNT)) begin
                        phase_save <= phase_cnt;
                        state      <= RX_DATA;
                    end else begin
                        stable_cnt <= stable_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (sample) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_W'(`SERIAL_DATA_BITS - 1)) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    // stop slot is waited out but its value is not checked
                    if (sample) begin
                        state <= RX_DONE;
                    end
                end
                RX_DONE: begin
                    // held here until rx_go falls
                    state <= RX_DONE;
                end
                default: begin
                    state <= RX_WAIT_EDGE;
                end
            endcase
        end
    end

    assign rx_done = rx_go && (state == RX_DONE);

    // first bit in ends up in bit 0
    always_ff @(posedge clk) begin
        if (rx_go && state == RX_DATA && sample) begin
            rx_data <= {rxd_s, rx_data[`SERIAL_DATA_BITS-1:1]};
        end
    end

    a_bit_range: assert property (@(posedge clk) disable iff (!reset_n)
        bit_cnt <= BIT_W'(`SERIAL_DATA_BITS))
        else $error("bit counter past the data bits");

endmodule

/* design/serial_port.sv */
// top level of the serial port
// the host drives cmd and reads status; txd and rxd go to the line

module serial_port (
    input  logic                     clk,
    input  logic                     reset_n,
    input  serial_pkg::host_cmd_t    cmd,
    input  logic                     timer_trigger,
    input  logic                     rxd,
    output serial_pkg::host_status_t status,
    output logic                     txd
);

    import serial_pkg::*;

    logic         baud_tick;
    logic         tx_go;
    logic         rx_go;
    logic         tx_done;
    logic         rx_done;
    logic         ti;
    logic         ri;
    serial_byte_t rx_data;

    serial_ctrl serial_ctrl_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .cmd           (cmd),
        .timer_trigger (timer_trigger),
        .tx_done       (tx_done),
        .rx_done       (rx_done),
        .baud_tick     (baud_tick),
        .tx_go         (tx_go),
        .rx_go         (rx_go),
        .ti            (ti),
        .ri            (ri)
    );

    serial_tx serial_tx_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .tx_go     (tx_go),
        .baud_tick (baud_tick),
        .tx_data   (cmd.tx_data),
        .tx_done   (tx_done),
        .txd       (txd)
    );

    serial_rx serial_rx_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .rx_go     (rx_go),
        .baud_tick (baud_tick),
        .rxd       (rxd),
        .rx_done   (rx_done),
        .rx_data   (rx_data)
    );

    assign status = '{ti: ti, ri: ri, rx_data: rx_data};

endmodule

/* dv/tb_serial_port.sv */
// testbench for the serial port
// applies a table of sends and receives, with line models on txd and rxd

`include "serial_config.svh"

module tb_serial_port;

    timeunit 1ns;
    timeprecision 100ps;

    import serial_pkg::*;

    localparam int CLK_NS        = 4;
    localparam int BIT_CYCLES    = 16;
    localparam int RESET_CYCLES  = 16;
    localparam int NUM_ENTRIES   = 10;
    localparam int GLITCH_CYCLES = 4;
    localparam int GAP_CYCLES    = 8;
    localparam int WATCHDOG_NS   = NUM_ENTRIES * 14 * BIT_CYCLES * CLK_NS * 2
                                   + RESET_CYCLES * CLK_NS;

    typedef enum logic [1:0] {
        OP_SEND,
        OP_RECV,
        OP_RECV_GLITCH,
        OP_TX_BLOCKED
    } op_t;

    typedef struct packed {
        op_t          op;
        serial_byte_t data;
        logic         exp_flag;
    } entry_t;

    logic         clk = 1'b0;
    logic         reset_n;
    host_cmd_t    cmd;
    logic         timer_trigger;
    logic         rxd;
    host_status_t status;
    logic         txd;

    entry_t       stim_table [NUM_ENTRIES];
    logic [31:0]  lcg_state;
    logic         exp_ti;
    logic         exp_ri;
    int           mismatch_count;
    int           fail_count;

    serial_port serial_port_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .cmd           (cmd),
        .timer_trigger (timer_trigger),
        .rxd           (rxd),
        .status        (status),
        .txd           (txd)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // one trigger per bit time
    initial begin
        timer_trigger = 1'b0;
        forever begin
            repeat (BIT_CYCLES - 1) @(negedge clk);
            timer_trigger = 1'b1;
            @(negedge clk);
            timer_trigger = 1'b0;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run did not finish in time");
        $display("Something failed");
        $finish;
    end

    // ========================================================================
    // stimulus table
    // ========================================================================

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic op_t op_for_entry(input int idx);
        case (idx)
            0:       return OP_SEND;
            1:       return OP_RECV;
            2:       return OP_RECV_GLITCH;
            3:       return OP_TX_BLOCKED;
            default: return (idx % 2 == 0) ? OP_SEND : OP_RECV;
        endcase
    endfunction

    task automatic build_table();
        lcg_state = 32'h17b3_2f2f;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            lcg_state = lcg_next(lcg_state);
            stim_table[i].op       = op_for_entry(i);
            stim_table[i].data     = lcg_state[23:16];
            stim_table[i].exp_flag = (stim_table[i].op != OP_TX_BLOCKED);
        end
    endtask

    // ========================================================================
    // checks
    // ========================================================================

    task automatic check_byte(input string name, input serial_byte_t got,
                              input serial_byte_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_line(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_status(input host_status_t got, input host_status_t exp);
        if (got.ti !== exp.ti) begin
            $display("MISMATCH status.ti: got 0x%h expected 0x%h", got.ti, exp.ti);
            mismatch_count++;
        end
        if (got.ri !== exp.ri) begin
            $display("MISMATCH status.ri: got 0x%h expected 0x%h", got.ri, exp.ri);
            mismatch_count++;
        end
    endtask

    // flags against the host flag model
    task automatic expect_flags();
        host_status_t exp_status;
        exp_status = '{ti: exp_ti, ri: exp_ri, rx_data: '0};
        check_status(status, exp_status);
    endtask

    task automatic wait_flag(input bit use_ri, input int limit, output bit seen);
        int n;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(negedge clk);
            seen = use_ri ? status.ri : status.ti;
            n++;
        end
    endtask

    // ========================================================================
    // host and line models
    // ========================================================================

    task automatic pulse_start_tx(input serial_byte_t data);
        cmd.tx_data  = data;
        cmd.start_tx = 1'b1;
        @(negedge clk);
        cmd.start_tx = 1'b0;
        exp_ti       = 1'b0;
    endtask

    task automatic pulse_start_rx();
        cmd.start_rx = 1'b1;
        @(negedge clk);
        cmd.start_rx = 1'b0;
        exp_ri       = 1'b0;
    endtask

    task automatic capture_tx_frame(output serial_byte_t data, output logic start_bit,
                                    output logic stop_bit, output bit found);
        int n;
        n         = 0;
        found     = 1'b0;
        data      = '0;
        start_bit = 1'b1;
        stop_bit  = 1'b0;
        while (!found && n < 3 * BIT_CYCLES) begin
            @(negedge clk);
            found = (txd == 1'b0);
            n++;
        end
        if (found) begin
            // middle of the start bit, then one bit time per sample
            repeat (BIT_CYCLES / 2) @(negedge clk);
            start_bit = txd;
            for (int i = 0; i < `SERIAL_DATA_BITS; i++) begin
                repeat (BIT_CYCLES) @(negedge clk);
                data[i] = txd;
            end
            repeat (BIT_CYCLES) @(negedge clk);
            stop_bit = txd;
        end
    endtask

    task automatic drive_rx_frame(input serial_byte_t data);
        rxd = 1'b0;
        repeat (BIT_CYCLES) @(negedge clk);
        for (int i = 0; i < `SERIAL_DATA_BITS; i++) begin
            rxd = data[i];
            repeat (BIT_CYCLES) @(negedge clk);
        end
        rxd = 1'b1;
        repeat (BIT_CYCLES) @(negedge clk);
    endtask

    task automatic drive_rx_glitch();
        rxd = 1'b0;
        repeat (GLITCH_CYCLES) @(negedge clk);
        rxd = 1'b1;
    endtask

    // ========================================================================
    // operations
    // ========================================================================

    task automatic run_send(input entry_t e);
        serial_byte_t got;
        logic         start_bit;
        logic         stop_bit;
        bit           ok;
        cmd.rx_enable = 1'b0;
        pulse_start_tx(e.data);
        expect_flags();
        capture_tx_frame(got, start_bit, stop_bit, ok);
        if (!ok) begin
            $display("no start bit appeared on txd after start_tx");
            fail_count++;
        end else begin
            check_line("txd start bit", start_bit, 1'b0);
            check_byte("txd data", got, e.data);
            check_line("txd stop bit", stop_bit, 1'b1);
            // still inside the stop bit
            expect_flags();
            wait_flag(1'b0, 2 * BIT_CYCLES, ok);
            if (!ok) begin
                $display("ti did not rise after the frame was sent");
                fail_count++;
            end
            exp_ti = e.exp_flag;
            expect_flags();
        end
    endtask

    task automatic run_receive(input entry_t e, input bit glitch);
        bit ok;
        cmd.rx_enable = 1'b1;
        pulse_start_rx();
        expect_flags();
        repeat (4) @(negedge clk);
        if (glitch) begin
            drive_rx_glitch();
            // long enough for a falsely accepted start to reach ri
            repeat ((`SERIAL_DATA_BITS + 3) * BIT_CYCLES) @(negedge clk);
            expect_flags();
        end
        drive_rx_frame(e.data);
        wait_flag(1'b1, 2 * BIT_CYCLES, ok);
        if (!ok) begin
            $display("ri did not rise after the frame was received");
            fail_count++;
        end else begin
            exp_ri = e.exp_flag;
            expect_flags();
            check_byte("status.rx_data", status.rx_data, e.data);
        end
        cmd.rx_enable = 1'b0;
    endtask

    task automatic run_blocked(input entry_t e);
        logic line_idle;
        line_idle     = 1'b1;
        cmd.rx_enable = 1'b1;
        pulse_start_tx(e.data);
        for (int n = 0; n < 12 * BIT_CYCLES; n++) begin
            @(negedge clk);
            line_idle = line_idle & txd;
        end
        check_line("txd while blocked", line_idle, 1'b1);
        exp_ti = e.exp_flag;
        expect_flags();
        cmd.rx_enable = 1'b0;
    endtask

    // ========================================================================
    // main sequence
    // ========================================================================

    initial begin
        reset_n        = 1'b0;
        cmd            = '0;
        rxd            = 1'b1;
        exp_ti         = 1'b0;
        exp_ri         = 1'b0;
        mismatch_count = 0;
        fail_count     = 0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        // idle line and clear flags out of reset
        check_line("txd", txd, 1'b1);
        expect_flags();
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            case (stim_table[i].op)
                OP_SEND:        run_send(stim_table[i]);
                OP_RECV:        run_receive(stim_table[i], 1'b0);
                OP_RECV_GLITCH: run_receive(stim_table[i], 1'b1);
                default:        run_blocked(stim_table[i]);
            endcase
            repeat (GAP_CYCLES) @(negedge clk);
        end
        $display("mismatches: %0d, other errors: %0d", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+design
design/serial_pkg.sv
design/serial_ctrl.sv
design/serial_tx.sv
design/serial_rx.sv
design/serial_port.sv
dv/tb_serial_port.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = tb_serial_port
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
